// ==== sources.f ====
source/cpuPkg.sv
source/registerFile.sv
source/executeUnit.sv
source/memoryPort.sv
source/cpuSequencer.sv
source/cpuTop.sv
dv/cpu_properties.sv
dv/cpuTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cpuTb -f sources.f -Mdir obj_dir
	./obj_dir/VcpuTb +verilator+error+limit+1000 | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb;
  import cpuPkg::*;

  localparam int          MemWords      = 1024;
  localparam int          TimeoutCycles = 20000;
  localparam logic [31:0] RandomSeed    = 32'd67037;
  localparam dataWord     StackBase     = 32'h0000_0C00;
  localparam dataWord     DataArea      = 32'h0000_0900;
  localparam dataWord     SubAddr       = 32'h0000_0400;  // Subroutine for the call test
  localparam dataWord     TrapAddr      = 32'h0000_0500;  // Target of jumps that must not go

  logic    clk;
  logic    reset = 1'b1;
  logic    memReq;
  logic    memWrite;
  dataWord memAddress;
  dataWord memWriteData;
  dataWord memReadData = '0;
  logic    memAck = 1'b0;
  dataWord debugOut;
  logic    debugValid;

  dataWord     imageWords [MemWords];  // Program image copied into mem during reset
  dataWord     mem [MemWords];
  dataWord     expectedQueue [$];
  int          mismatchCount = 0;
  int          protocolCount = 0;
  int          otherCount = 0;
  int          seenCount = 0;
  int          progPtr;                // Word index while building
  logic [31:0] buildState;
  logic [31:0] delayState;
  logic [1:0]  delayLeft;
  logic        ackPending;
  dataWord     markVal;                // Running value of the marker register

  cpuTop #(.NumRegs(16)) dut (
    .clk, .reset, .memReq, .memWrite, .memAddress, .memWriteData,
    .memReadData, .memAck, .debugOut, .debugValid
  );

  bind cpuTop cpu_properties props (
    .clk, .reset, .memReq, .memAddress, .memAck, .debugValid, .debugOut
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Opcode in byte 0 with fields A B C above it
  function automatic dataWord encode(opCode op, int a, int b, int c);
    return {c[7:0], b[7:0], a[7:0], op};
  endfunction

  task automatic drawRandom(output dataWord value);
    buildState = xorshift32(buildState);
    value = buildState;
  endtask

  task automatic emit(dataWord w);
    imageWords[progPtr] = w;
    progPtr++;
  endtask

  task automatic emitOp(opCode op, int a, int b, int c);
    emit(encode(op, a, b, c));
  endtask

  task automatic emitLong(opCode op, int a, int b, int c, dataWord w);
    emitOp(op, a, b, c);
    emit(w);
  endtask

  task automatic expectOut(int r, dataWord value);
    emitOp(DoutR, r, 0, 0);
    expectedQueue.push_back(value);
  endtask

  task automatic emitMarker();
    expectOut(15, markVal);
    emitOp(IncR, 15, 0, 0);
    markVal = markVal + 32'd1;
  endtask

  // Taken jumps skip one bad output while others would land in the trap
  task automatic emitBranch(opCode op, int a, logic taken);
    dataWord target;
    target = (progPtr + 3) * 4;
    if (taken) begin
      emitLong(op, a, 0, 0, target);
      emitOp(DoutR, 12, 0, 0);
    end else begin
      emitLong(op, a, 0, 0, TrapAddr);
    end
    emitMarker();
  endtask

  task automatic buildProgram();
    dataWord x;
    dataWord y;
    dataWord k;
    dataWord m;
    dataWord t;
    logic [4:0] sh;
    logic [2:0] idx;
    int savedPtr;
    for (int i = 0; i < MemWords; i++) begin
      imageWords[i] = 32'hC0DE_0000 ^ 32'(i * 4);  // Byte address folded in
    end
    buildState = RandomSeed;
    progPtr = 0;
    drawRandom(x);
    x = x | 32'd1;       // Nonzero for the zero tests
    drawRandom(y);
    drawRandom(k);
    drawRandom(m);
    drawRandom(markVal);
    drawRandom(t);
    sh = t[4:0];
    idx = t[10:8];
    emitLong(MovRC, 0, 0, 0, StackBase);
    emitLong(MovRC, 2, 0, 0, x);
    emitLong(MovRC, 3, 0, 0, y);
    emitLong(MovRC, 4, 0, 0, {27'd0, sh});
    emitLong(MovRC, 12, 0, 0, 32'hBAD0_BAD0);  // Bad marker
    emitLong(MovRC, 15, 0, 0, markVal);
    emitOp(AddRRR, 5, 2, 3);
    expectOut(5, x + y);
    emitLong(SubRRC, 5, 2, 0, k);
    expectOut(5, x - k);
    emitOp(SubRRR, 5, 2, 3);
    expectOut(5, x - y);
    emitLong(AddRRC, 5, 3, 0, k);
    expectOut(5, y + k);
    emitOp(ShlRRR, 5, 2, 4);
    expectOut(5, x << sh);
    emitOp(ShrRRR, 5, 2, 4);
    expectOut(5, x >> sh);
    emitOp(NegRR, 5, 2, 0);
    expectOut(5, 32'd0 - x);
    emitOp(MovRR, 6, 2, 0);
    emitOp(IncR, 6, 0, 0);
    expectOut(6, x + 32'd1);
    emitOp(DecR, 6, 0, 0);
    emitOp(DecR, 6, 0, 0);
    expectOut(6, x - 32'd1);
    emitOp(MovRR, 7, 2, 0);
    emitLong(MulAddRRC, 7, 3, 0, m);
    expectOut(7, x + m * y);
    emitOp(CmpLtRRR, 8, 2, 3);
    expectOut(8, {31'd0, x < y});
    emitOp(CmpGtRRR, 8, 2, 3);
    expectOut(8, {31'd0, x > y});
    emitOp(CmpERRR, 8, 2, 2);
    expectOut(8, 32'd1);
    emitOp(CmpNeRRR, 8, 2, 3);
    expectOut(8, {31'd0, x != y});
    emitOp(CmpRR, 2, 3, 0);
    expectOut(1, {29'd0, x > y, x < y, x == y});
    emitLong(CmpRC, 3, 0, 0, k);
    expectOut(1, {29'd0, y > k, y < k, y == k});
    // Data memory, every addressing form
    emitLong(MovRC, 9, 0, 0, DataArea);
    emitLong(MovRC, 10, 0, 0, {29'd0, idx});
    emitLong(MovdCR, 0, 7, 0, DataArea);
    emitOp(MovRdR, 11, 9, 0);
    expectOut(11, x + m * y);
    emitLong(MovdRoRR, 9, 10, 2, 32'd4);
    emitLong(MovRdRoR, 11, 9, 10, 32'd4);
    expectOut(11, x);
    emitLong(MovdCR, 0, 3, 0, DataArea + 32'h40);
    emitLong(MovRdC, 11, 0, 0, DataArea + 32'h40);
    expectOut(11, y);
    emitLong(MovdRoR, 9, 5, 0, 32'h80);
    emitLong(MovRdRo, 11, 9, 0, 32'h80);
    expectOut(11, 32'd0 - x);
    // Stack and call
    emitOp(PushR, 3, 0, 0);
    emitOp(PopR, 13, 0, 0);
    expectOut(13, y);
    expectOut(0, StackBase);
    emitLong(MovRC, 14, 0, 0, SubAddr);
    emitOp(CallR, 14, 0, 0);
    savedPtr = progPtr;
    progPtr = SubAddr / 4;            // Subroutine body runs right at the call
    expectOut(0, StackBase + 32'd4);
    emitMarker();
    emitOp(Ret, 0, 0, 0);
    progPtr = savedPtr;
    expectOut(0, StackBase);          // Back after the call with the stack unwound
    // Jumps, taken and not taken
    emitLong(MovRC, 13, 0, 0, 32'd0);
    emitLong(CmpRC, 2, 0, 0, x);      // Equal flag set
    emitBranch(JeC, 0, 1'b1);
    emitBranch(JneC, 0, 1'b0);
    emitLong(CmpRC, 2, 0, 0, x + 32'd1);
    emitBranch(JeC, 0, 1'b0);
    emitBranch(JneC, 0, 1'b1);
    emitBranch(JzRC, 13, 1'b1);
    emitBranch(JnzRC, 13, 1'b0);
    emitBranch(JnzRC, 2, 1'b1);
    emitBranch(JzRC, 2, 1'b0);
    emitBranch(JmpC, 0, 1'b1);
    expectOut(2, x);                  // Final marker
    emitOp(Stall, 0, 0, 0);
    progPtr = TrapAddr / 4;
    emitOp(DoutR, 12, 0, 0);
    emitOp(Stall, 0, 0, 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Four-phase memory slave with 0 to 3 cycles of extra delay
  always @(posedge clk) begin
    if (reset) begin
      memAck      <= 1'b0;
      memReadData <= '0;
      ackPending  <= 1'b0;
      delayLeft   <= '0;
      delayState  <= RandomSeed;
      for (int i = 0; i < MemWords; i++) begin
        mem[i] <= imageWords[i];
      end
    end else if (memAck) begin
      if (!memReq) memAck <= 1'b0;   // Return to zero
    end else if (ackPending) begin
      if (delayLeft == 2'd0) begin
        memAck     <= 1'b1;
        ackPending <= 1'b0;
        if (memWrite) begin
          mem[memAddress[11:2]] <= memWriteData;
        end else begin
          memReadData <= mem[memAddress[11:2]];
        end
      end else begin
        delayLeft <= delayLeft - 2'd1;
      end
    end else if (memReq) begin
      ackPending <= 1'b1;
      delayLeft  <= delayState[1:0];  // Current state before the next draw
      delayState <= xorshift32(delayState);
    end
  end

  always @(negedge clk) begin
    if (debugValid) seenCount <= seenCount + 1;
  end

  initial begin
    int cycles;
    buildProgram();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (seenCount < expectedQueue.size() && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (seenCount < expectedQueue.size()) begin
      otherCount++;
      $display("ERROR: timeout after %0d cycles, %0d of %0d debug outputs seen",
               cycles, seenCount, expectedQueue.size());
    end else begin
      repeat (60) @(negedge clk);    // Core spins on the stall word
    end
    $display("Errors: %0d mismatches, %0d protocol, %0d other",
             mismatchCount, protocolCount, otherCount);
    if (mismatchCount + protocolCount + otherCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/cpu_properties.sv ====
`timescale 1ns/1ns

module cpu_properties (
  input logic            clk,
  input logic            reset,
  input logic            memReq,
  input cpuPkg::dataWord memAddress,
  input logic            memAck,
  input logic            debugValid,
  input cpuPkg::dataWord debugOut
);

  int checkIndex;  // Next entry of the expected queue

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      checkIndex <= 0;
    end else if (debugValid) begin
      checkIndex <= checkIndex + 1;
    end
  end

  // Bus quiet while reset is held
  resetIdle: assert property (@(posedge clk) reset |-> !memReq && !debugValid)
    else begin
      cpuTb.protocolCount++;
      $error("memReq or debugValid active during reset");
    end

  // Request held until the memory answers
  reqHold: assert property (@(posedge clk) disable iff (reset)
    memReq && !memAck |=> memReq)
    else begin
      cpuTb.protocolCount++;
      $error("memReq dropped before memAck");
    end

  reqRise: assert property (@(posedge clk) disable iff (reset) $rose(memReq) |-> !memAck)
    else begin
      cpuTb.protocolCount++;
      $error("memReq rose while memAck was still high");
    end

  addrStable: assert property (@(posedge clk) disable iff (reset)
    memReq && !memAck |=> $stable(memAddress))
    else begin
      cpuTb.protocolCount++;
      $error("memAddress changed during a pending request");
    end

  // More debug outputs than the program holds
  debugCount: assert property (@(posedge clk) disable iff (reset)
    debugValid |-> checkIndex < cpuTb.expectedQueue.size())
    else begin
      cpuTb.mismatchCount++;
      $error("debugOut fired more often than the program expects");
    end

  debugValue: assert property (@(posedge clk) disable iff (reset)
    debugValid && checkIndex < cpuTb.expectedQueue.size() |->
      debugOut == cpuTb.expectedQueue[checkIndex])
    else begin
      cpuTb.mismatchCount++;
      $error("MISMATCH time %0t debugOut got %h expected %h", $time, debugOut,
             cpuTb.expectedQueue[checkIndex]);
    end

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop #(
  parameter int NumRegs = 16
) (
  input  logic            clk,
  input  logic            reset,
  output logic            memReq,
  output logic            memWrite,
  output cpuPkg::dataWord memAddress,
  output cpuPkg::dataWord memWriteData,
  input  cpuPkg::dataWord memReadData,
  input  logic            memAck,
  output cpuPkg::dataWord debugOut,
  output logic            debugValid
);
  import cpuPkg::*;

  localparam int RegAddrWidth = $clog2(NumRegs);

  // Sequencer to memory port
  logic    memStart;
  logic    memStore;
  logic    memDone;
  dataWord memReqAddress;
  dataWord memStoreData;
  dataWord memData;
  // Register file links
  logic [RegAddrWidth-1:0] regAddrA;
  logic [RegAddrWidth-1:0] regAddrB;
  logic [RegAddrWidth-1:0] regAddrC;
  logic [RegAddrWidth-1:0] regWriteAddr;
  dataWord    regDataA;
  dataWord    regDataB;
  dataWord    regDataC;
  logic       regWrite;
  stackAdjust spAdjust;
  dataWord    stackPointer;
  dataWord    flags;
  // Execute links
  opCode   opValue;
  dataWord operandA;
  dataWord operandB;
  dataWord operandC;
  dataWord constWord;
  dataWord loadedWord;
  dataWord ipointer;
  dataWord writeData;
  dataWord flagsResult;
  dataWord accessAddress;
  dataWord storeData;
  logic    flagsWrite;
  logic    branchTaken;

  cpuSequencer #(.NumRegs(NumRegs)) sequencer (
    .clk, .reset,
    .memStart, .memStore, .memReqAddress, .memStoreData, .memDone, .memData,
    .regAddrA, .regAddrB, .regAddrC, .regDataA, .regDataB, .regDataC,
    .regWrite, .regWriteAddr, .spAdjust,
    .opValue, .operandA, .operandB, .operandC,
    .dataWord(constWord), .loadedWord, .ipointer,
    .branchTaken, .accessAddress, .storeData,
    .debugOut, .debugValid
  );

  registerFile #(.NumRegs(NumRegs)) regFile (
    .clk, .reset,
    .addrA(regAddrA), .addrB(regAddrB), .addrC(regAddrC),
    .dataA(regDataA), .dataB(regDataB), .dataC(regDataC),
    .writeEnable(regWrite), .writeAddr(regWriteAddr), .writeData,
    .flagsWrite, .flagsData(flagsResult), .spAdjust,
    .stackPointer, .flags
  );

  executeUnit execUnit (
    .opValue, .operandA, .operandB, .operandC,
    .dataWord(constWord), .loadedWord, .flags, .stackPointer, .ipointer,
    .writeData, .flagsWrite, .flagsResult, .branchTaken, .accessAddress, .storeData
  );

  memoryPort memPort (
    .clk, .reset,
    .start(memStart), .store(memStore), .address(memReqAddress), .storeData(memStoreData),
    .done(memDone), .readData(memData),
    .memReq, .memWrite, .memAddress, .memWriteData, .memAck, .memReadData
  );

endmodule

// ==== source/cpuSequencer.sv ====
`timescale 1ns/1ns

module cpuSequencer #(
  parameter int NumRegs = 16,
  localparam int RegAddrWidth = $clog2(NumRegs)
) (
  input  logic                    clk,
  input  logic                    reset,
  output logic                    memStart,
  output logic                    memStore,
  output cpuPkg::dataWord         memReqAddress,
  output cpuPkg::dataWord         memStoreData,
  input  logic                    memDone,
  input  cpuPkg::dataWord         memData,
  output logic [RegAddrWidth-1:0] regAddrA,
  output logic [RegAddrWidth-1:0] regAddrB,
  output logic [RegAddrWidth-1:0] regAddrC,
  input  cpuPkg::dataWord         regDataA,
  input  cpuPkg::dataWord         regDataB,
  input  cpuPkg::dataWord         regDataC,
  output logic                    regWrite,
  output logic [RegAddrWidth-1:0] regWriteAddr,
  output cpuPkg::stackAdjust      spAdjust,
  output cpuPkg::opCode           opValue,
  output cpuPkg::dataWord         operandA,
  output cpuPkg::dataWord         operandB,
  output cpuPkg::dataWord         operandC,
  output cpuPkg::dataWord         dataWord,
  output cpuPkg::dataWord         loadedWord,
  output cpuPkg::dataWord         ipointer,
  input  logic                    branchTaken,
  input  cpuPkg::dataWord         accessAddress,
  input  cpuPkg::dataWord         storeData,
  output cpuPkg::dataWord         debugOut,
  output logic                    debugValid
);
  import cpuPkg::*;

  seqState              state;
  logic                 waiting;      // Access issued and done not yet seen
  logic [DataWidth-1:0] instrWord;
  logic                 needsMemory;
  logic                 inExecute;

  // Opcodes that write through the Execute strobe including flags
  function automatic logic writesRegister(opCode op);
    case (op)
      MovRC, MovRR, MovRdC, MovRdR, MovRdRo, MovRdRoR, PopR,
      CmpRR, CmpRC, CmpERRR, CmpNeRRR, CmpLtRRR, CmpGtRRR,
      AddRRC, AddRRR, SubRRC, SubRRR, IncR, DecR,
      ShlRRR, ShrRRR, NegRR, MulAddRRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign needsMemory = isLoadOp(opValue) || isStoreOp(opValue);
  assign inExecute   = state == Execute;

  // One start per memory state
  assign memStart = !waiting &&
                    (state == FetchInstr || state == FetchData || state == MemAccess);
  assign memStore = (state == MemAccess) && isStoreOp(opValue);
  assign memStoreData = storeData;

  always_comb begin
    case (state)
      FetchData: memReqAddress = ipointer + 32'd4;   // Word after the opcode
      MemAccess: memReqAddress = accessAddress;
      default:   memReqAddress = ipointer;
    endcase
  end

  assign regWrite     = inExecute && writesRegister(opValue);
  assign regWriteAddr = regAddrA;       // Destination is always field A

  always_comb begin
    spAdjust = SpHold;
    if (inExecute) begin
      case (opValue)
        PushR, CallR: spAdjust = SpUp;
        PopR, Ret:    spAdjust = SpDown;
        default:      spAdjust = SpHold;
      endcase
    end
  end

  assign debugValid = inExecute && (opValue == DoutR);
  assign debugOut   = operandA;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= FetchInstr;
      waiting  <= 1'b0;
      ipointer <= '0;
      opValue  <= Stall;
    end else begin
      if (memStart) begin
        waiting <= 1'b1;
      end else if (memDone) begin
        waiting <= 1'b0;
      end
      case (state)
        FetchInstr: begin
          if (memDone) state <= Decode;
        end
        Decode: begin
          opValue <= opCode'(instrWord[7:0]);
          state   <= RegRead;
        end
        RegRead: begin
          if (isLongOp(opValue)) begin
            state <= FetchData;
          end else if (needsMemory) begin
            state <= MemAccess;
          end else begin
            state <= Execute;
          end
        end
        FetchData: begin
          if (memDone) state <= needsMemory ? MemAccess : Execute;
        end
        MemAccess: begin
          if (memDone) state <= Execute;
        end
        Execute: begin
          // Next instruction address
          if (opValue == Stall) begin
            ipointer <= ipointer;        // Spin on the stall word
          end else if (branchTaken || opValue == JmpC) begin
            ipointer <= dataWord;
          end else if (opValue == CallR) begin
            ipointer <= operandA;
          end else if (opValue == Ret) begin
            ipointer <= loadedWord + StackStep;   // Skip the call itself
          end else if (isLongOp(opValue)) begin
            ipointer <= ipointer + 32'd8;
          end else begin
            ipointer <= ipointer + 32'd4;
          end
          state <= FetchInstr;
        end
        default: state <= FetchInstr;
      endcase
    end
  end

  // Instruction payload latches
  always_ff @(posedge clk) begin
    if (state == FetchInstr && memDone) begin
      instrWord <= memData;
    end
    if (state == Decode) begin
      regAddrA <= instrWord[8 +: RegAddrWidth];    // Fields modulo NumRegs
      regAddrB <= instrWord[16 +: RegAddrWidth];
      regAddrC <= instrWord[24 +: RegAddrWidth];
    end
    if (state == RegRead) begin
      operandA <= regDataA;
      operandB <= regDataB;
      operandC <= regDataC;
    end
    if (state == FetchData && memDone) begin
      dataWord <= memData;
    end
    if (state == MemAccess && memDone) begin
      loadedWord <= memData;
    end
  end

endmodule

// ==== source/memoryPort.sv ====
`timescale 1ns/1ns

module memoryPort (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,        // One-cycle access request
  input  logic            store,
  input  cpuPkg::dataWord address,
  input  cpuPkg::dataWord storeData,
  output logic            done,         // One-cycle completion
  output cpuPkg::dataWord readData,
  output logic            memReq,
  output logic            memWrite,
  output cpuPkg::dataWord memAddress,
  output cpuPkg::dataWord memWriteData,
  input  logic            memAck,
  input  cpuPkg::dataWord memReadData
);

  typedef enum logic [1:0] {Idle, Request, Release} portState;

  portState state;

  // Four-phase handshake control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= Idle;
      memReq   <= 1'b0;
      memWrite <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        Idle: begin
          if (start) begin
            memReq   <= 1'b1;      // Rises the cycle after start
            memWrite <= store;
            state    <= Request;
          end
        end
        Request: begin
          if (memAck) begin
            memReq   <= 1'b0;
            memWrite <= 1'b0;
            state    <= Release;
          end
        end
        Release: begin
          // Wait for the memory to drop ack
          if (!memAck) begin
            done  <= 1'b1;
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Address and write data held stable for the whole request
  always_ff @(posedge clk) begin
    if (state == Idle && start) begin
      memAddress   <= address;
      memWriteData <= storeData;
    end
    if (state == Request && memAck) begin
      readData <= memReadData;   // Valid while ack high
    end
  end

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/1ns

module executeUnit (
  input  cpuPkg::opCode   opValue,
  input  cpuPkg::dataWord operandA,
  input  cpuPkg::dataWord operandB,
  input  cpuPkg::dataWord operandC,
  input  cpuPkg::dataWord dataWord,      // Second instruction word
  input  cpuPkg::dataWord loadedWord,    // Result of the data read
  input  cpuPkg::dataWord flags,
  input  cpuPkg::dataWord stackPointer,
  input  cpuPkg::dataWord ipointer,
  output cpuPkg::dataWord writeData,
  output logic            flagsWrite,
  output cpuPkg::dataWord flagsResult,
  output logic            branchTaken,
  output cpuPkg::dataWord accessAddress,
  output cpuPkg::dataWord storeData
);
  import cpuPkg::*;

  logic [DataWidth-1:0] compareRight;
  logic [DataWidth-1:0] mulRight;
  logic [DataWidth-1:0] product;
  logic                 isEqual;
  logic                 isLess;
  logic                 isGreater;

  // Flag compare of A against B or the constant
  assign compareRight = (opValue == CmpRC) ? dataWord : operandB;
  assign isEqual   = operandA == compareRight;
  assign isLess    = operandA < compareRight;   // Unsigned
  assign isGreater = operandA > compareRight;

  assign flagsWrite  = (opValue == CmpRR) || (opValue == CmpRC);
  assign flagsResult = {{(DataWidth - 3){1'b0}}, isGreater, isLess, isEqual};

  // One multiplier shared by scaled index and multiply-add
  assign mulRight = (opValue == MovRdRoR) ? operandC : operandB;
  assign product  = dataWord * mulRight;

  always_comb begin
    case (opValue)
      MovRC:                                writeData = dataWord;
      MovRR:                                writeData = operandB;
      MovRdC, MovRdR, MovRdRo, MovRdRoR, PopR: writeData = loadedWord;
      CmpERRR:   writeData = DataWidth'(operandB == operandC);
      CmpNeRRR:  writeData = DataWidth'(operandB != operandC);
      CmpLtRRR:  writeData = DataWidth'(operandB < operandC);
      CmpGtRRR:  writeData = DataWidth'(operandB > operandC);
      AddRRC:    writeData = operandB + dataWord;
      AddRRR:    writeData = operandB + operandC;
      SubRRC:    writeData = operandB - dataWord;
      SubRRR:    writeData = operandB - operandC;
      IncR:      writeData = operandA + 1'b1;
      DecR:      writeData = operandA - 1'b1;
      ShlRRR:    writeData = operandB << operandC;
      ShrRRR:    writeData = operandB >> operandC;   // Logical
      NegRR:     writeData = -operandB;
      MulAddRRC: writeData = operandA + product;
      default:   writeData = '0;
    endcase
  end

  // Jump conditions with the target taken from the sequencer
  always_comb begin
    case (opValue)
      JeC:     branchTaken = flags[0];
      JneC:    branchTaken = !flags[0];
      JzRC:    branchTaken = operandA == '0;
      JnzRC:   branchTaken = operandA != '0;
      default: branchTaken = 1'b0;
    endcase
  end

  always_comb begin
    case (opValue)
      MovRdC, MovdCR: accessAddress = dataWord;
      MovRdR:         accessAddress = operandB;
      MovRdRo:        accessAddress = operandB + dataWord;
      MovRdRoR:       accessAddress = operandB + product;  // Base B, index C
      MovdRoR:        accessAddress = operandA + dataWord;
      MovdRoRR:       accessAddress = operandA + product;  // Base A, index B
      PushR, CallR:   accessAddress = stackPointer;        // Stack grows up
      PopR, Ret:      accessAddress = stackPointer - StackStep;
      default:        accessAddress = '0;
    endcase
  end

  always_comb begin
    case (opValue)
      PushR:    storeData = operandA;
      CallR:    storeData = ipointer;   // Return lands after the call
      MovdRoRR: storeData = operandC;
      default:  storeData = operandB;   // MovdCR, MovdRoR
    endcase
  end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ns

module registerFile #(
  parameter int NumRegs = 16,
  localparam int RegAddrWidth = $clog2(NumRegs)
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [RegAddrWidth-1:0] addrA,
  input  logic [RegAddrWidth-1:0] addrB,
  input  logic [RegAddrWidth-1:0] addrC,
  output cpuPkg::dataWord         dataA,
  output cpuPkg::dataWord         dataB,
  output cpuPkg::dataWord         dataC,
  input  logic                    writeEnable,  // Execute write strobe
  input  logic [RegAddrWidth-1:0] writeAddr,
  input  cpuPkg::dataWord         writeData,
  input  logic                    flagsWrite,   // Redirects the strobe to the flags
  input  cpuPkg::dataWord         flagsData,
  input  cpuPkg::stackAdjust      spAdjust,
  output cpuPkg::dataWord         stackPointer,
  output cpuPkg::dataWord         flags
);
  import cpuPkg::*;

  dataWord regs [NumRegs];

  // Three combinational read ports
  assign dataA = regs[addrA];
  assign dataB = regs[addrB];
  assign dataC = regs[addrC];

  assign stackPointer = regs[StackPointerReg];
  assign flags        = regs[FlagsReg];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (writeEnable) begin
        if (flagsWrite) begin
          regs[FlagsReg] <= flagsData;    // Compares land in the flags
        end else begin
          regs[writeAddr] <= writeData;
        end
      end
      // Stack pointer moves alongside a pop destination write
      case (spAdjust)
        SpUp:    regs[StackPointerReg] <= regs[StackPointerReg] + StackStep;
        SpDown:  regs[StackPointerReg] <= regs[StackPointerReg] - StackStep;
        default: ;
      endcase
    end
  end

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

  localparam int DataWidth = 32; // Data and address word

  typedef logic [DataWidth-1:0] dataWord;

  // Byte 0 of every instruction word
  typedef enum logic [7:0] {
    Stall = 8'd0,
    MovRC, MovRR, MovRdC, MovRdR, MovRdRo, MovRdRoR,
    MovdCR, MovdRoR, MovdRoRR,
    PushR, PopR, CallR, Ret,
    JmpC, JeC, JneC, JzRC, JnzRC,
    CmpRR, CmpRC, CmpERRR, CmpNeRRR, CmpLtRRR, CmpGtRRR,
    AddRRC, AddRRR, SubRRC, SubRRR, IncR, DecR,
    ShlRRR, ShrRRR, NegRR, MulAddRRC,
    DoutR
  } opCode;

  typedef enum logic [2:0] {
    FetchInstr, Decode, RegRead, FetchData, MemAccess, Execute
  } seqState;

  typedef enum logic [1:0] {SpHold, SpUp, SpDown} stackAdjust;

  localparam int StackPointerReg = 0;
  localparam int FlagsReg = 1;        // Bit 0 equal, bit 1 less, bit 2 greater
  localparam dataWord StackStep = 4;  // Bytes per stack slot

  // Opcodes followed by a constant or offset word
  function automatic logic isLongOp(opCode op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovRdRoR, MovdCR, MovdRoR, MovdRoRR,
      JmpC, JeC, JneC, JzRC, JnzRC, CmpRC, AddRRC, SubRRC, MulAddRRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Data reads in MemAccess
  function automatic logic isLoadOp(opCode op);
    case (op)
      MovRdC, MovRdR, MovRdRo, MovRdRoR, PopR, Ret: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Data writes in MemAccess
  function automatic logic isStoreOp(opCode op);
    case (op)
      MovdCR, MovdRoR, MovdRoRR, PushR, CallR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage
